// File: filelist.f
hw/fetch_pkg.sv
hw/sync_fifo.sv
hw/ibar_detect.sv
hw/fetch_queue.sv
hw/fetch_buffer_top.sv
tests/tb_fetch_buffer_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch buffer testbench with Verilator.
set -e

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_buffer_top \
    --Mdir "$OBJ_DIR" -o sim_fetch_buffer \
    -f filelist.f

"./$OBJ_DIR/sim_fetch_buffer" 2>&1 | tee "$LOG_FILE"

if grep -q "Simulation failed" "$LOG_FILE"; then
    echo "FAIL: see $LOG_FILE"
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG_FILE"; then
    echo "FAIL: run ended without a verdict, see $LOG_FILE"
    exit 1
fi
echo "PASS"

// File: tests/tb_fetch_buffer_top.sv
`timescale 1ns/1ps

module tb_fetch_buffer_top;

    import fetch_pkg::*;

    localparam int DEPTH      = 4;
    localparam int WAIT_LIMIT = 40;

    localparam fetch_pair_t IDLE_PAIR = '{
        inst1: INST_NOP,
        inst0: INST_NOP,
        pc:    PC_RESET,
        badv:  PC_RESET
    };

    localparam fetch_status_t IDLE_STATUS = '{
        cookie:         COOKIE_IDLE,
        exception:      7'd0,
        cacop_ready:    1'b0,
        cacop_complete: 1'b0
    };

    logic          clk;
    logic          rst_n;
    logic          push;
    logic          pop;
    fetch_pair_t   in_pair;
    fetch_status_t in_status;
    fetch_pair_t   out_pair;
    fetch_status_t out_status;
    logic          empty;
    logic          full;
    logic          ibar;
    logic          ibar_pos;
    logic [31:0]   ibar_pc;

    // reference model and expected outputs
    fetch_pair_t   model_pair_q[$];
    fetch_status_t model_stat_q[$];
    fetch_pair_t   popped_log[$];
    fetch_pair_t   dut_popped[$];
    fetch_pair_t   exp_pair;
    fetch_status_t exp_status;
    logic          exp_empty;
    logic          exp_full;
    logic          exp_ibar;
    logic          exp_pos;
    logic [31:0]   exp_pc;

    int err_value;
    int err_other;
    int n_bypass;
    int n_drop;
    int n_full_swap;
    int n_ibar;

    fetch_buffer_top #(
        .DEPTH (DEPTH)
    ) u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .push_i       (push),
        .in_pair_i    (in_pair),
        .in_status_i  (in_status),
        .pop_i        (pop),
        .out_pair_o   (out_pair),
        .out_status_o (out_status),
        .empty_o      (empty),
        .full_o       (full),
        .ibar_o       (ibar),
        .ibar_pos_o   (ibar_pos),
        .ibar_pc_o    (ibar_pc)
    );

    always #2 clk = ~clk;

    // ####################
    // checks
    // ####################

    a_pair: assert property (@(posedge clk) disable iff (!rst_n) out_pair == exp_pair)
        else begin
            err_value++;
            $display("Error at %0t: out_pair_o %h, expected %h", $time, out_pair, exp_pair);
        end

    a_status: assert property (@(posedge clk) disable iff (!rst_n) out_status == exp_status)
        else begin
            err_value++;
            $display("Error at %0t: out_status_o %h, expected %h", $time, out_status,
                     exp_status);
        end

    a_empty: assert property (@(posedge clk) disable iff (!rst_n) empty == exp_empty)
        else begin
            err_value++;
            $display("Error at %0t: empty_o %b, expected %b", $time, empty, exp_empty);
        end

    a_full: assert property (@(posedge clk) disable iff (!rst_n) full == exp_full)
        else begin
            err_value++;
            $display("Error at %0t: full_o %b, expected %b", $time, full, exp_full);
        end

    a_ibar: assert property (@(posedge clk) disable iff (!rst_n) ibar == exp_ibar)
        else begin
            err_value++;
            $display("Error at %0t: ibar_o %b, expected %b", $time, ibar, exp_ibar);
        end

    a_ibar_slot: assert property (@(posedge clk) disable iff (!rst_n)
                                  exp_ibar |-> (ibar_pos == exp_pos && ibar_pc == exp_pc))
        else begin
            err_value++;
            $display("Error at %0t: ibar slot %b pc %h, expected slot %b pc %h", $time,
                     ibar_pos, ibar_pc, exp_pos, exp_pc);
        end

    // ####################
    // model
    // ####################

    function automatic logic is_ibar(input logic [31:0] inst);
        return (inst & IBAR_MASK) == IBAR_MATCH;
    endfunction

    function automatic fetch_pair_t rand_pair();
        fetch_pair_t p;
        p.inst1 = $urandom();
        p.inst0 = $urandom();
        p.pc    = $urandom() & 32'hffff_fffc;
        p.badv  = $urandom();
        return p;
    endfunction

    function automatic fetch_status_t rand_status();
        fetch_status_t s;
        s.cookie         = $urandom();
        s.exception      = 7'($urandom());
        s.cacop_ready    = 1'($urandom());
        s.cacop_complete = 1'($urandom());
        return s;
    endfunction

    // account for the rising edge that just passed
    task automatic apply_edge();
        int   size;
        logic bypass;
        logic accept;
        logic hit0;
        logic hit1;
        size = model_pair_q.size();
        if (!rst_n) begin
            model_pair_q.delete();
            model_stat_q.delete();
            exp_ibar = 1'b0;
        end else begin
            bypass   = (size == 0) && push && pop;
            accept   = push && (bypass || size < DEPTH || (pop && size > 0));
            hit0     = is_ibar(in_pair.inst0);
            hit1     = is_ibar(in_pair.inst1);
            exp_ibar = accept && (hit0 || hit1);
            if (exp_ibar) begin
                exp_pos = !hit0;
                exp_pc  = hit0 ? in_pair.pc : in_pair.pc + 32'd4;
                n_ibar++;
            end
            if (bypass) begin
                popped_log.push_back(in_pair);
                n_bypass++;
            end else begin
                if (pop && size > 0) begin
                    popped_log.push_back(model_pair_q.pop_front());
                    void'(model_stat_q.pop_front());
                end
                if (accept) begin
                    model_pair_q.push_back(in_pair);
                    model_stat_q.push_back(in_status);
                    if (size == DEPTH) begin
                        n_full_swap++;
                    end
                end else if (push) begin
                    n_drop++;
                end
            end
        end
    endtask

    task automatic update_expected();
        int size;
        size      = model_pair_q.size();
        exp_empty = (size == 0);
        exp_full  = (size == DEPTH);
        if (exp_empty && push && pop) begin
            exp_pair   = in_pair;
            exp_status = in_status;
        end else if (!exp_empty) begin
            exp_pair   = model_pair_q[0];
            exp_status = model_stat_q[0];
        end else begin
            exp_pair   = IDLE_PAIR;
            exp_status = IDLE_STATUS;
        end
    endtask

    // ####################
    // stimulus
    // ####################

    task automatic drive_cycle(input logic do_push, input logic do_pop,
                               input fetch_pair_t pair, input fetch_status_t stat);
        @(negedge clk);
        apply_edge();
        push      = do_push;
        pop       = do_pop;
        in_pair   = pair;
        in_status = stat;
        update_expected();
        // what decode takes at the coming edge
        #1;
        if (rst_n && pop && (!empty || push)) begin
            dut_popped.push_back(out_pair);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, 1'b0, rand_pair(), rand_status());
        end
    endtask

    task automatic drain();
        int n;
        idle_cycles(1);
        n = 0;
        while (!empty && n < WAIT_LIMIT) begin
            drive_cycle(1'b0, 1'b1, rand_pair(), rand_status());
            n++;
        end
        if (!empty) begin
            err_other++;
            $display("Timeout: buffer did not drain within %0d pops", WAIT_LIMIT);
        end
        idle_cycles(1);
    endtask

    task automatic fill_and_overflow();
        fetch_pair_t drop_pair;
        int          n;
        repeat (DEPTH) begin
            drive_cycle(1'b1, 1'b0, rand_pair(), rand_status());
        end
        n = 0;
        while (!full && n < WAIT_LIMIT) begin
            idle_cycles(1);
            n++;
        end
        if (!full) begin
            err_other++;
            $display("Timeout: full_o never rose after %0d pushes", DEPTH);
        end
        // lone push while full is lost along with its barrier
        drop_pair       = rand_pair();
        drop_pair.inst0 = IBAR_MATCH | 32'h0000_0007;
        drive_cycle(1'b1, 1'b0, drop_pair, rand_status());
        drive_cycle(1'b1, 1'b1, rand_pair(), rand_status());
        idle_cycles(1);
        drain();
        foreach (dut_popped[i]) begin
            assert (dut_popped[i] != drop_pair) else begin
                err_value++;
                $display("Error at %0t: dropped pair %h reached decode", $time, drop_pair);
            end
        end
    endtask

    task automatic push_ibar_pairs();
        fetch_pair_t pair_a;
        fetch_pair_t pair_b;
        pair_a       = rand_pair();
        pair_a.inst0 = INST_NOP;
        pair_a.inst1 = IBAR_MATCH | 32'h0000_0012;
        pair_b       = rand_pair();
        pair_b.inst0 = IBAR_MATCH;
        pair_b.inst1 = IBAR_MATCH | 32'h0000_0001;
        drive_cycle(1'b1, 1'b0, pair_a, rand_status());
        idle_cycles(2);
        drive_cycle(1'b1, 1'b0, pair_b, rand_status());
        idle_cycles(2);
    endtask

    task automatic check_popped();
        assert (dut_popped.size() == popped_log.size()) else begin
            err_value++;
            $display("Error at %0t: decode took %0d pairs, expected %0d", $time,
                     dut_popped.size(), popped_log.size());
        end
        foreach (popped_log[i]) begin
            if (i < dut_popped.size()) begin
                assert (dut_popped[i] == popped_log[i]) else begin
                    err_value++;
                    $display("Error at %0t: pop %0d gave %h, expected %h", $time, i,
                             dut_popped[i], popped_log[i]);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(47));
        clk         = 1'b0;
        rst_n       = 1'b0;
        push        = 1'b0;
        pop         = 1'b0;
        in_pair     = '0;
        in_status   = '0;
        exp_pair    = IDLE_PAIR;
        exp_status  = IDLE_STATUS;
        exp_empty   = 1'b1;
        exp_full    = 1'b0;
        exp_ibar    = 1'b0;
        exp_pos     = 1'b0;
        exp_pc      = '0;
        err_value   = 0;
        err_other   = 0;
        n_bypass    = 0;
        n_drop      = 0;
        n_full_swap = 0;
        n_ibar      = 0;

        idle_cycles(10);
        rst_n = 1'b1;
        assert (empty && !full && !ibar) else begin
            err_value++;
            $display("Error at %0t: flags after reset empty %b full %b ibar %b", $time,
                     empty, full, ibar);
        end
        idle_cycles(3);

        // burst in order, then drain
        repeat (DEPTH - 1) begin
            drive_cycle(1'b1, 1'b0, rand_pair(), rand_status());
        end
        drain();
        idle_cycles(2);

        // push and pop together on an empty buffer
        repeat (2) begin
            drive_cycle(1'b1, 1'b1, rand_pair(), rand_status());
            idle_cycles(1);
        end

        // random traffic
        repeat (80) begin
            drive_cycle(1'($urandom()), 1'($urandom()), rand_pair(), rand_status());
        end
        drain();

        fill_and_overflow();
        push_ibar_pairs();
        drain();
        idle_cycles(3);
        check_popped();

        if (n_bypass == 0 || n_drop == 0 || n_full_swap == 0 || n_ibar < 2) begin
            err_other++;
            $display("Stimulus missed a case: bypass %0d, drop %0d, full swap %0d, ibar %0d",
                     n_bypass, n_drop, n_full_swap, n_ibar);
        end

        $display("Checks done: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // whole run limit
    initial begin
        #20000;
        err_other++;
        $display("Watchdog expired before the test sequence finished");
        $display("Checks done: %0d value errors, %0d other errors", err_value, err_other);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: hw/fetch_buffer_top.sv
`timescale 1ns/1ps

module fetch_buffer_top #(
    parameter int DEPTH = fetch_pkg::FETCH_DEPTH_DEFAULT
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // fetch side
    input  logic                     push_i,
    input  fetch_pkg::fetch_pair_t   in_pair_i,
    input  fetch_pkg::fetch_status_t in_status_i,

    // decode side
    input  logic                     pop_i,
    output fetch_pkg::fetch_pair_t   out_pair_o,
    output fetch_pkg::fetch_status_t out_status_o,
    output logic                     empty_o,
    output logic                     full_o,

    // barrier report
    output logic                     ibar_o,
    output logic                     ibar_pos_o,
    output logic [31:0]              ibar_pc_o
);

    // accepted push, full check lives in the queue
    logic push_ok;

    fetch_queue #(
        .DEPTH (DEPTH)
    ) u_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push_i),
        .pop_i        (pop_i),
        .in_pair_i    (in_pair_i),
        .in_status_i  (in_status_i),
        .out_pair_o   (out_pair_o),
        .out_status_o (out_status_o),
        .empty_o      (empty_o),
        .full_o       (full_o),
        .push_ok_o    (push_ok)
    );

    ibar_detect u_ibar (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .push_ok_i  (push_ok),
        .pair_i     (in_pair_i),
        .ibar_o     (ibar_o),
        .ibar_pos_o (ibar_pos_o),
        .ibar_pc_o  (ibar_pc_o)
    );

endmodule

// File: hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int DEPTH = fetch_pkg::FETCH_DEPTH_DEFAULT
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     push_i,
    input  logic                     pop_i,
    input  fetch_pkg::fetch_pair_t   in_pair_i,
    input  fetch_pkg::fetch_status_t in_status_i,
    output fetch_pkg::fetch_pair_t   out_pair_o,
    output fetch_pkg::fetch_status_t out_status_o,
    output logic                     empty_o,
    output logic                     full_o,
    output logic                     push_ok_o
);

    import fetch_pkg::*;

    // what decode sees with nothing buffered
    localparam fetch_pair_t PAIR_IDLE = '{
        inst1: INST_NOP,
        inst0: INST_NOP,
        pc:    PC_RESET,
        badv:  PC_RESET
    };

    localparam fetch_status_t STATUS_IDLE = '{
        cookie:         COOKIE_IDLE,
        exception:      7'd0,
        cacop_ready:    1'b0,
        cacop_complete: 1'b0
    };

    logic          buf_empty;
    logic          buf_full;
    logic          bypass;
    logic          push_ok;
    logic          wr_en;
    logic          rd_en;
    fetch_pair_t   head_pair;
    fetch_status_t head_stat;

    // ####################
    // handshake
    // ####################

    // empty buffer with push and pop together skips storage
    assign bypass = buf_empty && push_i && pop_i;

    // full buffer still takes a push when decode pops in the same cycle
    assign push_ok = push_i && (bypass || !buf_full || pop_i);

    assign wr_en = push_ok && !bypass;
    assign rd_en = pop_i && !buf_empty;

    // ####################
    // storage
    // ####################

    // both buffers see the same strobes and stay co-indexed
    sync_fifo #(
        .payload_t (fetch_pair_t),
        .DEPTH     (DEPTH)
    ) u_pair_buf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en),
        .wr_data_i (in_pair_i),
        .rd_en_i   (rd_en),
        .rd_data_o (head_pair),
        .empty_o   (buf_empty),
        .full_o    (buf_full)
    );

    // flags of this one are redundant
    sync_fifo #(
        .payload_t (fetch_status_t),
        .DEPTH     (DEPTH)
    ) u_stat_buf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en),
        .wr_data_i (in_status_i),
        .rd_en_i   (rd_en),
        .rd_data_o (head_stat),
        .empty_o   (),
        .full_o    ()
    );

    // ####################
    // output select
    // ####################

    always_comb begin
        if (bypass) begin
            out_pair_o   = in_pair_i;
            out_status_o = in_status_i;
        end else if (!buf_empty) begin
            out_pair_o   = head_pair;
            out_status_o = head_stat;
        end else begin
            out_pair_o   = PAIR_IDLE;
            out_status_o = STATUS_IDLE;
        end
    end

    assign empty_o   = buf_empty;
    assign full_o    = buf_full;
    assign push_ok_o = push_ok;

endmodule

// File: hw/ibar_detect.sv
`timescale 1ns/1ps

module ibar_detect (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_ok_i,
    input  fetch_pkg::fetch_pair_t pair_i,
    output logic                   ibar_o,
    output logic                   ibar_pos_o,
    output logic [31:0]            ibar_pc_o
);

    import fetch_pkg::*;

    logic        hit0;
    logic        hit1;
    logic        hit;
    logic        ibar_q;
    logic        pos_q;
    logic [31:0] pc_q;

    // ####################
    // opcode match
    // ####################

    // hint bits are masked off
    assign hit0 = (pair_i.inst0 & IBAR_MASK) == IBAR_MATCH;
    assign hit1 = (pair_i.inst1 & IBAR_MASK) == IBAR_MATCH;
    assign hit  = hit0 || hit1;

    // ####################
    // report registers
    // ####################

    // one-cycle pulse per accepted pair with a barrier
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ibar_q <= 1'b0;
        end else begin
            ibar_q <= push_ok_i && hit;
        end
    end

    // slot 0 wins when both slots hold ibar
    always_ff @(posedge clk_i) begin
        if (push_ok_i && hit) begin
            pos_q <= !hit0;
            pc_q  <= hit0 ? pair_i.pc : pair_i.pc + 32'd4;
        end
    end

    assign ibar_o     = ibar_q;
    assign ibar_pos_o = pos_q;
    assign ibar_pc_o  = pc_q;

endmodule

// File: hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     wr_en_i,
    input  payload_t wr_data_i,
    input  logic     rd_en_i,
    output payload_t rd_data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic             empty_q;
    logic             full_q;
    logic             do_wr;
    logic             do_rd;

    // a read in the same cycle frees a slot for the write when full
    assign do_rd = rd_en_i && !empty_q;
    assign do_wr = wr_en_i && (!full_q || do_rd);

    always_comb begin
        cnt_d = cnt_q;
        if (do_wr && !do_rd) begin
            cnt_d = cnt_q + 1'b1;
        end else if (do_rd && !do_wr) begin
            cnt_d = cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            empty_q  <= 1'b1;
            full_q   <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q   <= cnt_d;
            // flags follow the next count so they stay registered
            empty_q <= (cnt_d == '0);
            full_q  <= (cnt_d == CNT_FULL);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    // head entry, no read latency
    assign rd_data_o = mem[rd_ptr_q];
    assign empty_o   = empty_q;
    assign full_o    = full_q;

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

    // ####################
    // fetch group payload
    // ####################

    // pc belongs to inst0, inst1 sits at pc + 4
    typedef struct packed {
        logic [31:0] inst1;
        logic [31:0] inst0;
        logic [31:0] pc;
        logic [31:0] badv;
    } fetch_pair_t;

    // icache side info that travels with a pair
    typedef struct packed {
        logic [31:0] cookie;
        logic [6:0]  exception;
        logic        cacop_ready;
        logic        cacop_complete;
    } fetch_status_t;

    // ####################
    // front-end constants
    // ####################

    // andi r0,r0,0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // reset pc, also used as badv of the idle pair
    localparam logic [31:0] PC_RESET = 32'h1c00_0000;

    // ibar opcode in bits 31:15, low 15 bits are the hint
    localparam logic [31:0] IBAR_MASK  = 32'hffff_8000;
    localparam logic [31:0] IBAR_MATCH = 32'h3872_8000;

    // cookie shown to decode while nothing is buffered
    localparam logic [31:0] COOKIE_IDLE = 32'd1919810;

    // buffer depth unless the top level says otherwise
    localparam int FETCH_DEPTH_DEFAULT = 8;

endpackage
